// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_eth_mac
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== axis_frame_fifo.sv ====
`timescale 1ns/1ps

module axis_frame_fifo #(
    parameter int DEPTH = 256
) (
    input  logic                logic_clk,
    input  logic                logic_rst,
    input  eth_pkg::axis_beat_t in_beat,
    input  logic                in_valid,
    output logic                in_ready,
    output eth_pkg::axis_beat_t out_beat,
    output logic                out_valid,
    input  logic                out_ready,
    output logic                overflow,
    output logic                bad_frame,
    output logic                good_frame
);
    import eth_pkg::*;

    // DEPTH must be a power of two, pointers carry one extra wrap bit
    localparam int AW = $clog2(DEPTH);

    axis_beat_t mem [DEPTH];

    logic [AW:0] wr_ptr;
    logic [AW:0] wr_ptr_commit;
    logic [AW:0] rd_ptr;
    logic        drop_frame;
    logic        full;
    logic        empty;
    logic        wr_en;
    logic        rd_en;

    // Full is judged on the speculative pointer, empty on the committed one
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty = (rd_ptr == wr_ptr_commit);
    assign wr_en = in_valid && in_ready && !drop_frame && !full;
    assign rd_en = !empty && (!out_valid || out_ready);

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            in_ready      <= 1'b0;
            wr_ptr        <= '0;
            wr_ptr_commit <= '0;
            rd_ptr        <= '0;
            drop_frame    <= 1'b0;
            out_valid     <= 1'b0;
            overflow      <= 1'b0;
            bad_frame     <= 1'b0;
            good_frame    <= 1'b0;
        end else begin
            // Drop mode, the input never stalls
            in_ready   <= 1'b1;
            overflow   <= 1'b0;
            bad_frame  <= 1'b0;
            good_frame <= 1'b0;

            if (in_valid && in_ready) begin
                if (drop_frame) begin
                    // Discard the tail of an overflowed frame
                    if (in_beat.last) begin
                        drop_frame <= 1'b0;
                    end
                end else if (full) begin
                    overflow   <= 1'b1;
                    wr_ptr     <= wr_ptr_commit;
                    drop_frame <= !in_beat.last;
                end else if (in_beat.last) begin
                    if (in_beat.user) begin
                        bad_frame <= 1'b1;
                        wr_ptr    <= wr_ptr_commit;
                    end else begin
                        good_frame    <= 1'b1;
                        wr_ptr        <= wr_ptr + 1'b1;
                        wr_ptr_commit <= wr_ptr + 1'b1;
                    end
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end

            // Output register refills whenever it is empty or being taken
            if (rd_en) begin
                rd_ptr    <= rd_ptr + 1'b1;
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= in_beat;
        end
        if (rd_en) begin
            out_beat <= mem[rd_ptr[AW-1:0]];
        end
    end

endmodule

// ==== eth_mac_fifo.sv ====
`timescale 1ns/1ps

module eth_mac_fifo #(
    parameter int MIN_FRAME_LENGTH = 64,
    parameter int TX_FIFO_DEPTH    = 256,
    parameter int RX_FIFO_DEPTH    = 256
) (
    input  logic                logic_clk,
    input  logic                logic_rst,
    input  eth_pkg::axis_beat_t tx_axis,
    input  logic                tx_axis_valid,
    output logic                tx_axis_ready,
    output eth_pkg::axis_beat_t rx_axis,
    output logic                rx_axis_valid,
    input  logic                rx_axis_ready,
    output eth_pkg::gmii_t      gmii_tx,
    input  eth_pkg::gmii_t      gmii_rx,
    input  logic [7:0]          ifg_delay,
    output logic                tx_error_underflow,
    output logic                tx_fifo_overflow,
    output logic                tx_fifo_bad_frame,
    output logic                tx_fifo_good_frame,
    output logic                rx_error_bad_frame,
    output logic                rx_error_bad_fcs,
    output logic                rx_fifo_overflow,
    output logic                rx_fifo_bad_frame,
    output logic                rx_fifo_good_frame
);
    import eth_pkg::*;

    // FIFO to MAC on the transmit side
    axis_beat_t tx_fifo_beat;
    logic       tx_fifo_valid;
    logic       tx_fifo_ready;

    // MAC to FIFO on the receive side, no back-pressure possible
    axis_beat_t rx_mac_beat;
    logic       rx_mac_valid;

    axis_frame_fifo #(
        .DEPTH(TX_FIFO_DEPTH)
    ) tx_fifo (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .in_beat   (tx_axis),
        .in_valid  (tx_axis_valid),
        .in_ready  (tx_axis_ready),
        .out_beat  (tx_fifo_beat),
        .out_valid (tx_fifo_valid),
        .out_ready (tx_fifo_ready),
        .overflow  (tx_fifo_overflow),
        .bad_frame (tx_fifo_bad_frame),
        .good_frame(tx_fifo_good_frame)
    );

    eth_mac_tx #(
        .MIN_FRAME_LENGTH(MIN_FRAME_LENGTH)
    ) eth_mac_tx_inst (
        .logic_clk      (logic_clk),
        .logic_rst      (logic_rst),
        .in_beat        (tx_fifo_beat),
        .in_valid       (tx_fifo_valid),
        .in_ready       (tx_fifo_ready),
        .gmii_tx        (gmii_tx),
        .ifg_delay      (ifg_delay),
        .error_underflow(tx_error_underflow)
    );

    eth_mac_rx eth_mac_rx_inst (
        .logic_clk      (logic_clk),
        .logic_rst      (logic_rst),
        .gmii_rx        (gmii_rx),
        .out_beat       (rx_mac_beat),
        .out_valid      (rx_mac_valid),
        .error_bad_frame(rx_error_bad_frame),
        .error_bad_fcs  (rx_error_bad_fcs)
    );

    axis_frame_fifo #(
        .DEPTH(RX_FIFO_DEPTH)
    ) rx_fifo (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .in_beat   (rx_mac_beat),
        .in_valid  (rx_mac_valid),
        .in_ready  (),
        .out_beat  (rx_axis),
        .out_valid (rx_axis_valid),
        .out_ready (rx_axis_ready),
        .overflow  (rx_fifo_overflow),
        .bad_frame (rx_fifo_bad_frame),
        .good_frame(rx_fifo_good_frame)
    );

endmodule

// ==== eth_mac_rx.sv ====
`timescale 1ns/1ps

module eth_mac_rx (
    input  logic                logic_clk,
    input  logic                logic_rst,
    input  eth_pkg::gmii_t      gmii_rx,
    output eth_pkg::axis_beat_t out_beat,
    output logic                out_valid,
    output logic                error_bad_frame,
    output logic                error_bad_fcs
);
    import eth_pkg::*;

    rx_state_t       state;
    logic [3:0][7:0] dly;
    logic [2:0]      fill;
    logic [7:0]      hold;
    logic            hold_valid;
    logic            err_seen;
    logic [31:0]     crc;
    logic            crc_bad;

    assign crc_bad = (crc != CRC_RESIDUE);

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state           <= RX_IDLE;
            dly             <= '0;
            fill            <= '0;
            hold            <= '0;
            hold_valid      <= 1'b0;
            err_seen        <= 1'b0;
            crc             <= '1;
            out_beat        <= '0;
            out_valid       <= 1'b0;
            error_bad_frame <= 1'b0;
            error_bad_fcs   <= 1'b0;
        end else begin
            out_valid       <= 1'b0;
            error_bad_frame <= 1'b0;
            error_bad_fcs   <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (gmii_rx.en) begin
                        state <= (!gmii_rx.er && gmii_rx.d == 8'h55) ? RX_PREAMBLE : RX_DROP;
                    end
                end
                RX_PREAMBLE: begin
                    if (!gmii_rx.en) begin
                        state <= RX_IDLE;
                    end else if (gmii_rx.er) begin
                        state <= RX_DROP;
                    end else if (gmii_rx.d == 8'hD5) begin
                        crc        <= '1;
                        fill       <= '0;
                        hold_valid <= 1'b0;
                        err_seen   <= 1'b0;
                        state      <= RX_DATA;
                    end else if (gmii_rx.d != 8'h55) begin
                        state <= RX_DROP;
                    end
                end
                RX_DATA: begin
                    if (gmii_rx.en) begin
                        dly <= {dly[2:0], gmii_rx.d};
                        crc <= crc32_step(crc, gmii_rx.d);
                        // Four newest bytes may be the FCS, only older ones move on
                        if (fill != 3'd4) begin
                            fill <= fill + 3'd1;
                        end else begin
                            hold       <= dly[3];
                            hold_valid <= 1'b1;
                        end
                        if (hold_valid) begin
                            out_beat  <= '{data: hold, last: 1'b0, user: 1'b0};
                            out_valid <= 1'b1;
                        end
                        if (gmii_rx.er) begin
                            err_seen <= 1'b1;
                        end
                    end else begin
                        // End of frame, the held byte is the last payload byte
                        if (hold_valid) begin
                            out_beat  <= '{data: hold, last: 1'b1, user: err_seen || crc_bad};
                            out_valid <= 1'b1;
                        end
                        error_bad_frame <= err_seen || !hold_valid;
                        error_bad_fcs   <= !err_seen && hold_valid && crc_bad;
                        state           <= RX_IDLE;
                    end
                end
                RX_DROP: begin
                    if (!gmii_rx.en) begin
                        state <= RX_IDLE;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== eth_mac_sva.sv ====
`timescale 1ns/1ps

module eth_mac_sva (
    input logic           logic_clk,
    input logic           logic_rst,
    input logic           tx_axis_valid,
    input logic           tx_axis_ready,
    input eth_pkg::gmii_t gmii_tx,
    input logic [7:0]     ifg_delay,
    input logic [8:0]     status
);
    import eth_pkg::*;

    int          fail_cnt = 0;
    logic        seen_xfer;
    logic [15:0] idle_cnt;

    // Idle count saturates so the first frame after reset passes
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            seen_xfer <= 1'b0;
            idle_cnt  <= '1;
        end else begin
            seen_xfer <= seen_xfer || (tx_axis_valid && tx_axis_ready);
            if (gmii_tx.en) begin
                idle_cnt <= '0;
            end else if (idle_cnt != '1) begin
                idle_cnt <= idle_cnt + 16'd1;
            end
        end
    end

    quiet_after_reset: assert property (@(posedge logic_clk) disable iff (logic_rst)
        !seen_xfer |-> !gmii_tx.en)
        else begin fail_cnt++; $error("gmii_tx.en high before any transfer"); end

    preamble_sfd: assert property (@(posedge logic_clk) disable iff (logic_rst)
        $rose(gmii_tx.en) |-> (gmii_tx.en && gmii_tx.d == 8'h55) [*7]
        ##1 (gmii_tx.en && gmii_tx.d == 8'hD5))
        else begin fail_cnt++; $error("frame does not start with preamble and SFD"); end

    gap_length: assert property (@(posedge logic_clk) disable iff (logic_rst)
        $rose(gmii_tx.en) |-> idle_cnt >= 16'(ifg_delay))
        else begin fail_cnt++; $error("inter-frame gap too short"); end

    single_pulse: assert property (@(posedge logic_clk) disable iff (logic_rst)
        (status & $past(status)) == 9'd0)
        else begin fail_cnt++; $error("status output high for more than one cycle"); end

endmodule

bind eth_mac_fifo eth_mac_sva sva_inst (
    .logic_clk    (logic_clk),
    .logic_rst    (logic_rst),
    .tx_axis_valid(tx_axis_valid),
    .tx_axis_ready(tx_axis_ready),
    .gmii_tx      (gmii_tx),
    .ifg_delay    (ifg_delay),
    .status       ({rx_fifo_good_frame, rx_fifo_bad_frame, rx_fifo_overflow,
                    rx_error_bad_fcs, rx_error_bad_frame, tx_fifo_good_frame,
                    tx_fifo_bad_frame, tx_fifo_overflow, tx_error_underflow})
);

// ==== eth_mac_tx.sv ====
`timescale 1ns/1ps

module eth_mac_tx #(
    parameter int MIN_FRAME_LENGTH = 64
) (
    input  logic                logic_clk,
    input  logic                logic_rst,
    input  eth_pkg::axis_beat_t in_beat,
    input  logic                in_valid,
    output logic                in_ready,
    output eth_pkg::gmii_t      gmii_tx,
    input  logic [7:0]          ifg_delay,
    output logic                error_underflow
);
    import eth_pkg::*;

    // Data bytes before the FCS in a minimum-size frame
    localparam logic [15:0] MIN_DATA = 16'(MIN_FRAME_LENGTH - 4);

    tx_state_t   state;
    logic [15:0] byte_cnt;
    logic [7:0]  cnt;
    logic [31:0] crc;

    // Beats are only taken while payload is going out
    assign in_ready = (state == TX_DATA);

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state           <= TX_IDLE;
            gmii_tx         <= '0;
            byte_cnt        <= '0;
            cnt             <= '0;
            crc             <= '1;
            error_underflow <= 1'b0;
        end else begin
            gmii_tx         <= '0;
            error_underflow <= 1'b0;
            case (state)
                TX_IDLE: begin
                    if (in_valid) begin
                        gmii_tx <= '{d: 8'h55, en: 1'b1, er: 1'b0};
                        cnt     <= 8'd1;
                        state   <= TX_PREAMBLE;
                    end
                end
                TX_PREAMBLE: begin
                    gmii_tx.en <= 1'b1;
                    if (cnt < 8'd7) begin
                        gmii_tx.d <= 8'h55;
                        cnt       <= cnt + 8'd1;
                    end else begin
                        // Start delimiter
                        gmii_tx.d <= 8'hD5;
                        crc       <= '1;
                        byte_cnt  <= '0;
                        state     <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    // user bit is not looked at, bad frames never leave the FIFO
                    if (in_valid) begin
                        gmii_tx  <= '{d: in_beat.data, en: 1'b1, er: 1'b0};
                        crc      <= crc32_step(crc, in_beat.data);
                        byte_cnt <= byte_cnt + 16'd1;
                        cnt      <= '0;
                        if (in_beat.last) begin
                            state <= (byte_cnt + 16'd1 < MIN_DATA) ? TX_PAD : TX_FCS;
                        end
                    end else begin
                        // Source ran dry mid-frame, poison it and stop
                        gmii_tx         <= '{d: 8'h00, en: 1'b1, er: 1'b1};
                        error_underflow <= 1'b1;
                        cnt             <= '0;
                        state           <= TX_IFG;
                    end
                end
                TX_PAD: begin
                    gmii_tx  <= '{d: 8'h00, en: 1'b1, er: 1'b0};
                    crc      <= crc32_step(crc, 8'h00);
                    byte_cnt <= byte_cnt + 16'd1;
                    if (byte_cnt + 16'd1 >= MIN_DATA) begin
                        state <= TX_FCS;
                    end
                end
                TX_FCS: begin
                    // Inverted CRC, low byte first
                    gmii_tx <= '{d: ~crc[7:0], en: 1'b1, er: 1'b0};
                    crc     <= {8'h00, crc[31:8]};
                    cnt     <= cnt + 8'd1;
                    if (cnt == 8'd3) begin
                        cnt   <= '0;
                        state <= TX_IFG;
                    end
                end
                TX_IFG: begin
                    // At least one idle cycle even with ifg_delay of zero
                    cnt <= cnt + 8'd1;
                    if (9'(cnt) + 9'd1 >= 9'(ifg_delay)) begin
                        state <= TX_IDLE;
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== eth_pkg.sv ====
package eth_pkg;

    // One byte-wide stream beat, user marks a bad frame on the last beat
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } axis_beat_t;

    // One GMII symbol
    typedef struct packed {
        logic [7:0] d;
        logic       en;
        logic       er;
    } gmii_t;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_PREAMBLE,
        TX_DATA,
        TX_PAD,
        TX_FCS,
        TX_IFG
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_PREAMBLE,
        RX_DATA,
        RX_DROP
    } rx_state_t;

    // CRC register value left behind by a frame whose FCS is correct
    localparam logic [31:0] CRC_RESIDUE = 32'hDEBB20E3;

    // Reflected CRC-32, one byte per call, LSB first
    function automatic logic [31:0] crc32_step(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'h000000, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
        end
        return c;
    endfunction

endpackage

// ==== src.f ====
eth_pkg.sv
axis_frame_fifo.sv
eth_mac_tx.sv
eth_mac_rx.sv
eth_mac_fifo.sv
eth_mac_sva.sv
tb_eth_mac.sv

// ==== tb_eth_mac.sv ====
`timescale 1ns/1ps

module tb_eth_mac;
    import eth_pkg::*;

    localparam int IFG = 12;
    // Wire bytes of all tests and the frame count for the run limit
    localparam int FRAME_BYTES = 892;
    localparam int NUM_FRAMES  = 9;
    localparam int CYCLE_LIMIT = (FRAME_BYTES + NUM_FRAMES * 40 + 200) * 4;

    logic       logic_clk;
    logic       logic_rst;
    axis_beat_t tx_axis;
    logic       tx_axis_valid;
    logic       tx_axis_ready;
    axis_beat_t rx_axis;
    logic       rx_axis_valid;
    logic       rx_axis_ready;
    gmii_t      gmii_tx;
    gmii_t      gmii_rx;
    logic [7:0] ifg_delay;
    logic [8:0] status;

    int          errors = 0;
    int          tests = 0;
    int          cycles = 0;
    int          en_cycles = 0;
    int          en_cnt = 0;
    int          flip_at = 0;
    logic        flip_armed;
    logic [31:0] lfsr;
    logic [8:0]  exp_beat;
    logic [8:0]  exp_q[$];
    // One counter per status bit
    int          pulses[9];

    eth_mac_fifo #(
        .TX_FIFO_DEPTH(512)
    ) DUT (
        .logic_clk         (logic_clk),
        .logic_rst         (logic_rst),
        .tx_axis           (tx_axis),
        .tx_axis_valid     (tx_axis_valid),
        .tx_axis_ready     (tx_axis_ready),
        .rx_axis           (rx_axis),
        .rx_axis_valid     (rx_axis_valid),
        .rx_axis_ready     (rx_axis_ready),
        .gmii_tx           (gmii_tx),
        .gmii_rx           (gmii_rx),
        .ifg_delay         (ifg_delay),
        .tx_error_underflow(status[0]),
        .tx_fifo_overflow  (status[1]),
        .tx_fifo_bad_frame (status[2]),
        .tx_fifo_good_frame(status[3]),
        .rx_error_bad_frame(status[4]),
        .rx_error_bad_fcs  (status[5]),
        .rx_fifo_overflow  (status[6]),
        .rx_fifo_bad_frame (status[7]),
        .rx_fifo_good_frame(status[8])
    );

    always #50 logic_clk = ~logic_clk;

    // Loopback with an optional single bit error
    always_comb begin
        gmii_rx = gmii_tx;
        if (flip_armed && gmii_tx.en && en_cnt == flip_at) begin
            gmii_rx.d[3] = ~gmii_tx.d[3];
        end
    end

    always @(posedge logic_clk) begin
        cycles <= cycles + 1;
        en_cnt <= gmii_tx.en ? en_cnt + 1 : 0;
        if (!logic_rst) begin
            en_cycles <= en_cycles + int'(gmii_tx.en);
            for (int i = 0; i < 9; i++) begin
                pulses[i] <= pulses[i] + int'(status[i]);
            end
        end
    end

    always @(posedge logic_clk) begin
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // Scoreboard on the receive stream
    always @(posedge logic_clk) begin
        if (!logic_rst && rx_axis_valid && rx_axis_ready) begin
            if (exp_q.size() == 0) begin
                $display("unexpected beat on rx_axis, nothing was queued");
                errors++;
            end else begin
                exp_beat = exp_q.pop_front();
                assert (rx_axis.data == exp_beat[8:1]) else begin
                    $display("ERR rx_axis.data got %h expected %h", rx_axis.data, exp_beat[8:1]);
                    errors++;
                end
                assert (rx_axis.last == exp_beat[0]) else begin
                    $display("ERR rx_axis.last got %h expected %h", rx_axis.last, exp_beat[0]);
                    errors++;
                end
                assert (!rx_axis.user) else begin
                    $display("ERR rx_axis.user got %h expected %h", rx_axis.user, 1'b0);
                    errors++;
                end
            end
        end
    end

    // Galois LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic get_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic push_beat(input logic [7:0] d, input logic last, input logic user);
        tx_axis       = '{data: d, last: last, user: user};
        tx_axis_valid = 1'b1;
        while (!tx_axis_ready) begin
            @(negedge logic_clk);
        end
        @(negedge logic_clk);
        tx_axis_valid = 1'b0;
    endtask

    // Short frames come back padded with zeros to 60 bytes
    task automatic send_frame(input int len, input logic bad, input logic expect_rx);
        logic [7:0] b;
        int         total;
        total = (len < 60) ? 60 : len;
        for (int i = 0; i < len; i++) begin
            get_byte(b);
            if (expect_rx) begin
                exp_q.push_back({b, i == total - 1});
            end
            push_beat(b, i == len - 1, bad && i == len - 1);
        end
        for (int i = len; i < total && expect_rx; i++) begin
            exp_q.push_back({8'h00, i == total - 1});
        end
    endtask

    task automatic wait_rx_done();
        while (exp_q.size() != 0) begin
            @(negedge logic_clk);
        end
        repeat (4) @(negedge logic_clk);
    endtask

    task automatic check_count(input string name, input int got, input int expected);
        assert (got == expected) else begin
            $display("ERR %s got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "errors");
    endtask

    initial begin
        int e0;
        int base[9];
        int en0;
        logic_clk     = 1'b0;
        logic_rst     = 1'b1;
        tx_axis       = '0;
        tx_axis_valid = 1'b0;
        rx_axis_ready = 1'b1;
        ifg_delay     = 8'(IFG);
        flip_armed    = 1'b0;
        lfsr          = 32'h447a155b;
        repeat (3) @(posedge logic_clk);
        @(negedge logic_clk);
        logic_rst = 1'b0;
        @(negedge logic_clk);

        e0 = errors;
        base = pulses;
        send_frame(100, 1'b0, 1'b1);
        wait_rx_done();
        check_count("tx_fifo_good_frame", pulses[3] - base[3], 1);
        check_count("rx_fifo_good_frame", pulses[8] - base[8], 1);
        finish_test("loopback 100 bytes", e0);

        e0 = errors;
        base = pulses;
        send_frame(20, 1'b0, 1'b1);
        wait_rx_done();
        check_count("rx_error_bad_fcs", pulses[5] - base[5], 0);
        check_count("rx_error_bad_frame", pulses[4] - base[4], 0);
        finish_test("short frame padding", e0);

        e0 = errors;
        base = pulses;
        en0 = en_cycles;
        send_frame(64, 1'b1, 1'b0);
        while (pulses[2] == base[2]) begin
            @(negedge logic_clk);
        end
        repeat (100) @(negedge logic_clk);
        check_count("tx_fifo_bad_frame", pulses[2] - base[2], 1);
        check_count("gmii_tx.en cycles", en_cycles - en0, 0);
        check_count("rx_fifo_good_frame", pulses[8] - base[8], 0);
        finish_test("bad frame dropped", e0);

        // Preamble and SFD take wire bytes 0 to 7
        e0 = errors;
        base = pulses;
        flip_at = 8 + 30;
        flip_armed = 1'b1;
        send_frame(64, 1'b0, 1'b0);
        while (pulses[7] == base[7]) begin
            @(negedge logic_clk);
        end
        flip_armed = 1'b0;
        repeat (4) @(negedge logic_clk);
        check_count("rx_error_bad_fcs", pulses[5] - base[5], 1);
        check_count("rx_fifo_bad_frame", pulses[7] - base[7], 1);
        send_frame(64, 1'b0, 1'b1);
        wait_rx_done();
        check_count("rx_fifo_good_frame", pulses[8] - base[8], 1);
        finish_test("fcs error injection", e0);

        e0 = errors;
        base = pulses;
        rx_axis_ready = 1'b0;
        repeat (3) send_frame(80, 1'b0, 1'b1);
        while (pulses[8] - base[8] < 3) begin
            @(negedge logic_clk);
        end
        rx_axis_ready = 1'b1;
        wait_rx_done();
        rx_axis_ready = 1'b0;
        send_frame(300, 1'b0, 1'b0);
        while (pulses[6] == base[6]) begin
            @(negedge logic_clk);
        end
        while (gmii_tx.en) begin
            @(negedge logic_clk);
        end
        repeat (10) @(negedge logic_clk);
        rx_axis_ready = 1'b1;
        repeat (20) @(negedge logic_clk);
        check_count("rx_fifo_overflow", pulses[6] - base[6], 1);
        check_count("rx_fifo_good_frame", pulses[8] - base[8], 3);
        finish_test("rx back-pressure and overflow", e0);

        check_count("tx_error_underflow", pulses[0], 0);
        check_count("tx_fifo_overflow", pulses[1], 0);
        check_count("assertion failures", DUT.sva_inst.fail_cnt, 0);
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
